//--- pdp8_config.svh
// Word geometry and fixed encodings of the PDP-8 core
// Included by the package and by every RTL file that sizes fields from it
`ifndef PDP8_CONFIG_SVH
`define PDP8_CONFIG_SVH

// Machine word and memory address width
`define PDP8_WORD_W 12

// Offset inside one 128-word page
`define PDP8_OFFSET_W 7

// Page number, upper address bits
`define PDP8_PAGE_W 5

// Group 2 operate word with only HLT set
`define PDP8_HLT_WORD 12'o7402

`endif

//--- pdp8_pkg.sv
// Shared types of the PDP-8 core: words, instruction views, FSM states and controls
// Referenced with pdp8_pkg:: scoped names
`default_nettype none
`include "pdp8_config.svh"

package pdp8_pkg;

  typedef logic [`PDP8_WORD_W-1:0] word_t;

  typedef enum logic [2:0] {
    OP_AND = 3'd0,
    OP_TAD = 3'd1,
    OP_ISZ = 3'd2,
    OP_DCA = 3'd3,
    OP_JMS = 3'd4,
    OP_JMP = 3'd5,
    OP_IOT = 3'd6,
    OP_OPR = 3'd7
  } opcode_e;

  typedef struct packed {
    opcode_e                   opcode;
    logic                      indirect;
    logic                      page;      // 0 page zero, 1 current page
    logic [`PDP8_OFFSET_W-1:0] offset;
  } mem_ref_t;

  // Bit 8 clear selects group 1
  typedef struct packed {
    opcode_e opcode;
    logic    group;
    logic    cla;
    logic    cll;
    logic    cma;
    logic    cml;
    logic    rar;
    logic    ral;
    logic    bit1;   // BSW on a real machine, ignored here
    logic    iac;
  } operate_t;

  typedef union packed {
    mem_ref_t mem_ref;
    operate_t operate;
  } instr_u;

  typedef enum logic [5:0] {
    INIT, IDLE, FETCH_REQ, FETCH_LOAD, DECODE, EA_CALC,
    EA_IND_REQ, OPER_READ, EXEC, ISZ_INC, WRITE_REQ, HALT
  } seq_state_e;

  typedef enum logic [2:0] {AC_HOLD, AC_CLEAR, AC_AND, AC_TAD, AC_OPERATE} ac_op_e;

  typedef enum logic [2:0] {PC_HOLD, PC_START, PC_INC1, PC_INC2, PC_JUMP, PC_EA_INC} pc_op_e;

  typedef enum logic {ADDR_PC, ADDR_EA} addr_sel_e;

  typedef enum logic [1:0] {WD_AC, WD_MB, WD_PC_INC} wdata_sel_e;

  typedef struct packed {
    ac_op_e     ac_op;
    pc_op_e     pc_op;
    logic       ea_load_direct;
    logic       ea_load_indirect;
    logic       ir_load;
    logic       mb_load;
    logic       mb_inc;
    addr_sel_e  addr_sel;
    wdata_sel_e wdata_sel;
    logic       mem_write;
  } datapath_ctrl_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } mem_req_t;

endpackage

`default_nettype wire

//--- pdp8_sequencer.sv
// Control FSM of the PDP-8 core, one instruction at a time
// Decodes IR, steps the datapath through ctrl and handshakes the memory port
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_config.svh"

module pdp8_sequencer (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     run,
  input  pdp8_pkg::instr_u         ir,
  input  pdp8_pkg::word_t          mb,
  input  logic                     mem_ready,
  output pdp8_pkg::datapath_ctrl_t ctrl,
  output logic                     mem_valid,
  output logic                     idle,
  output logic                     halted
);

  pdp8_pkg::seq_state_e state, next_state;
  pdp8_pkg::seq_state_e exec_target, next_target;
  pdp8_pkg::opcode_e    opcode;

  assign opcode = ir.mem_ref.opcode;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      state       <= pdp8_pkg::INIT;
      exec_target <= pdp8_pkg::EXEC;
    end else begin
      state       <= next_state;
      exec_target <= next_target;
    end
  end

  always_comb begin
    next_state  = state;
    next_target = exec_target;
    case (state)
      pdp8_pkg::INIT:       next_state = pdp8_pkg::IDLE;
      pdp8_pkg::IDLE:       if (run) next_state = pdp8_pkg::FETCH_REQ;
      pdp8_pkg::FETCH_REQ:  if (mem_ready) next_state = pdp8_pkg::FETCH_LOAD;
      pdp8_pkg::FETCH_LOAD: next_state = pdp8_pkg::DECODE;
      pdp8_pkg::DECODE: begin
        if (ir == `PDP8_HLT_WORD) begin
          next_state = pdp8_pkg::HALT;
        end else if (opcode == pdp8_pkg::OP_IOT || opcode == pdp8_pkg::OP_OPR) begin
          next_state = pdp8_pkg::EXEC;                 // Operate and unsupported words
        end else begin
          next_state = pdp8_pkg::EA_CALC;
          case (opcode)
            pdp8_pkg::OP_AND,
            pdp8_pkg::OP_TAD,
            pdp8_pkg::OP_ISZ: next_target = pdp8_pkg::OPER_READ;
            pdp8_pkg::OP_DCA,
            pdp8_pkg::OP_JMS: next_target = pdp8_pkg::WRITE_REQ;
            default:          next_target = pdp8_pkg::EXEC;   // JMP
          endcase
        end
      end
      pdp8_pkg::EA_CALC:
        next_state = ir.mem_ref.indirect ? pdp8_pkg::EA_IND_REQ : exec_target;
      pdp8_pkg::EA_IND_REQ: if (mem_ready) next_state = exec_target;
      pdp8_pkg::OPER_READ:
        if (mem_ready) begin
          next_state = (opcode == pdp8_pkg::OP_ISZ) ? pdp8_pkg::ISZ_INC : pdp8_pkg::EXEC;
        end
      pdp8_pkg::ISZ_INC:    next_state = pdp8_pkg::WRITE_REQ;
      pdp8_pkg::WRITE_REQ:  if (mem_ready) next_state = pdp8_pkg::FETCH_REQ;
      pdp8_pkg::EXEC:       next_state = pdp8_pkg::FETCH_REQ;
      pdp8_pkg::HALT:       next_state = pdp8_pkg::IDLE;
      default:              next_state = pdp8_pkg::INIT;
    endcase
  end

  always_comb begin
    ctrl.ac_op            = pdp8_pkg::AC_HOLD;
    ctrl.pc_op            = pdp8_pkg::PC_HOLD;
    ctrl.ea_load_direct   = 1'b0;
    ctrl.ea_load_indirect = 1'b0;
    ctrl.ir_load          = 1'b0;
    ctrl.mb_load          = 1'b0;
    ctrl.mb_inc           = 1'b0;
    ctrl.addr_sel         = pdp8_pkg::ADDR_PC;
    ctrl.wdata_sel        = pdp8_pkg::WD_AC;
    ctrl.mem_write        = 1'b0;
    mem_valid             = 1'b0;
    idle                  = 1'b0;
    halted                = 1'b0;
    case (state)
      pdp8_pkg::INIT: ctrl.ac_op = pdp8_pkg::AC_CLEAR;
      pdp8_pkg::IDLE: begin
        idle = 1'b1;
        if (run) ctrl.pc_op = pdp8_pkg::PC_START;
      end
      pdp8_pkg::FETCH_REQ: begin
        mem_valid    = 1'b1;
        ctrl.ir_load = mem_ready;                      // IR takes the word on the transfer edge
      end
      pdp8_pkg::EA_CALC: ctrl.ea_load_direct = 1'b1;
      pdp8_pkg::EA_IND_REQ: begin
        mem_valid             = 1'b1;
        ctrl.addr_sel         = pdp8_pkg::ADDR_EA;
        ctrl.ea_load_indirect = mem_ready;
      end
      pdp8_pkg::OPER_READ: begin
        mem_valid     = 1'b1;
        ctrl.addr_sel = pdp8_pkg::ADDR_EA;
        ctrl.mb_load  = mem_ready;
      end
      pdp8_pkg::ISZ_INC: ctrl.mb_inc = 1'b1;
      pdp8_pkg::WRITE_REQ: begin
        mem_valid      = 1'b1;
        ctrl.addr_sel  = pdp8_pkg::ADDR_EA;
        ctrl.mem_write = 1'b1;
        case (opcode)
          pdp8_pkg::OP_DCA: begin
            ctrl.wdata_sel = pdp8_pkg::WD_AC;
            if (mem_ready) begin
              ctrl.ac_op = pdp8_pkg::AC_CLEAR;
              ctrl.pc_op = pdp8_pkg::PC_INC1;
            end
          end
          pdp8_pkg::OP_ISZ: begin
            ctrl.wdata_sel = pdp8_pkg::WD_MB;
            if (mem_ready) begin
              ctrl.pc_op = (mb == '0) ? pdp8_pkg::PC_INC2 : pdp8_pkg::PC_INC1;  // Skip on zero
            end
          end
          default: begin
            ctrl.wdata_sel = pdp8_pkg::WD_PC_INC;     // JMS return address
            if (mem_ready) ctrl.pc_op = pdp8_pkg::PC_EA_INC;
          end
        endcase
      end
      pdp8_pkg::EXEC: begin
        ctrl.pc_op = pdp8_pkg::PC_INC1;
        case (opcode)
          pdp8_pkg::OP_AND: ctrl.ac_op = pdp8_pkg::AC_AND;
          pdp8_pkg::OP_TAD: ctrl.ac_op = pdp8_pkg::AC_TAD;
          pdp8_pkg::OP_JMP: ctrl.pc_op = pdp8_pkg::PC_JUMP;
          pdp8_pkg::OP_OPR: if (!ir.operate.group) ctrl.ac_op = pdp8_pkg::AC_OPERATE;
          default: ;                                   // IOT runs as a no-op
        endcase
      end
      pdp8_pkg::HALT: halted = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- pdp8_accumulator.sv
// Accumulator and link register with AND, TAD, clear and group 1 operate
// Acts on the edge where the sequencer names an ac_op
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_config.svh"

module pdp8_accumulator (
  input  logic                     clock,
  input  logic                     resetN,
  input  pdp8_pkg::datapath_ctrl_t ctrl,
  input  pdp8_pkg::instr_u         ir,
  input  pdp8_pkg::word_t          mb,
  output pdp8_pkg::word_t          ac,
  output logic                     link
);

  logic [`PDP8_WORD_W:0] tad_sum;
  logic [`PDP8_WORD_W:0] iac_sum;
  pdp8_pkg::word_t       op_ac;
  logic                  op_link;

  assign tad_sum = {1'b0, ac} + {1'b0, mb};

  // Group 1 order: clears, complements, increment, then one rotate
  always_comb begin
    op_ac   = ac;
    op_link = link;
    if (ir.operate.cla) op_ac = '0;
    if (ir.operate.cll) op_link = 1'b0;
    if (ir.operate.cma) op_ac = ~op_ac;
    if (ir.operate.cml) op_link = ~op_link;
    iac_sum = {1'b0, op_ac} + {{`PDP8_WORD_W{1'b0}}, ir.operate.iac};
    op_ac   = iac_sum[`PDP8_WORD_W-1:0];
    if (iac_sum[`PDP8_WORD_W]) op_link = ~op_link;   // Carry out of IAC flips link
    if (ir.operate.rar) begin
      {op_ac, op_link} = {op_link, op_ac};
    end else if (ir.operate.ral) begin
      {op_link, op_ac} = {op_ac, op_link};
    end
  end

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (ctrl.ac_op)
        pdp8_pkg::AC_CLEAR: ac <= '0;
        pdp8_pkg::AC_AND:   ac <= ac & mb;
        pdp8_pkg::AC_TAD: begin
          ac <= tad_sum[`PDP8_WORD_W-1:0];
          if (tad_sum[`PDP8_WORD_W]) link <= ~link;
        end
        pdp8_pkg::AC_OPERATE: begin
          ac   <= op_ac;
          link <= op_link;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pdp8_address_unit.sv
// PC, effective address, instruction register and memory buffer of the core
// Also forms the outgoing memory request from the address and write-data selects
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_config.svh"

module pdp8_address_unit (
  input  logic                     clock,
  input  logic                     resetN,
  input  pdp8_pkg::datapath_ctrl_t ctrl,
  input  pdp8_pkg::word_t          start_pc,
  input  pdp8_pkg::word_t          ac,
  input  pdp8_pkg::word_t          mem_rdata,
  output pdp8_pkg::instr_u         ir,
  output pdp8_pkg::word_t          mb,
  output pdp8_pkg::mem_req_t       mem_req
);

  pdp8_pkg::word_t             pc;
  pdp8_pkg::word_t             ea;
  pdp8_pkg::word_t             pc_plus1;
  pdp8_pkg::word_t             ea_plus1;
  pdp8_pkg::word_t             direct_ea;
  logic [`PDP8_PAGE_W-1:0]     page_sel;

  assign pc_plus1 = pc + `PDP8_WORD_W'(1);
  assign ea_plus1 = ea + `PDP8_WORD_W'(1);

  // Page bit picks page zero or the page of the current instruction
  assign page_sel  = ir.mem_ref.page ? pc[`PDP8_WORD_W-1 -: `PDP8_PAGE_W] : '0;
  assign direct_ea = {page_sel, ir.mem_ref.offset};

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      pc <= '0;
    end else begin
      case (ctrl.pc_op)
        pdp8_pkg::PC_START:  pc <= start_pc;
        pdp8_pkg::PC_INC1:   pc <= pc_plus1;
        pdp8_pkg::PC_INC2:   pc <= pc + `PDP8_WORD_W'(2);
        pdp8_pkg::PC_JUMP:   pc <= ea;
        pdp8_pkg::PC_EA_INC: pc <= ea_plus1;         // JMS enters after the saved word
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.ea_load_direct) begin
      ea <= direct_ea;
    end else if (ctrl.ea_load_indirect) begin
      ea <= mem_rdata;                               // Pointer word just read
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.ir_load) begin
      ir <= mem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.mb_load) begin
      mb <= mem_rdata;
    end else if (ctrl.mb_inc) begin
      mb <= mb + `PDP8_WORD_W'(1);
    end
  end

  // Held steady by the sequencer while a request waits for ready
  always_comb begin
    mem_req.addr  = (ctrl.addr_sel == pdp8_pkg::ADDR_EA) ? ea : pc;
    mem_req.write = ctrl.mem_write;
    case (ctrl.wdata_sel)
      pdp8_pkg::WD_MB:     mem_req.wdata = mb;
      pdp8_pkg::WD_PC_INC: mem_req.wdata = pc_plus1;
      default:             mem_req.wdata = ac;
    endcase
  end

endmodule

`default_nettype wire

//--- pdp8_core.sv
// Top level of the PDP-8 core: sequencer, accumulator and address unit
// Memory is external on one valid/ready request port
`timescale 1ns/1ns
`default_nettype none

module pdp8_core (
  input  logic               clock,
  input  logic               resetN,
  input  logic               run,
  input  pdp8_pkg::word_t    start_pc,
  input  logic               mem_ready,
  input  pdp8_pkg::word_t    mem_rdata,
  output logic               mem_valid,
  output pdp8_pkg::mem_req_t mem_req,
  output pdp8_pkg::word_t    ac,
  output logic               link,
  output logic               idle,
  output logic               halted
);

  pdp8_pkg::datapath_ctrl_t ctrl;
  pdp8_pkg::instr_u         ir;
  pdp8_pkg::word_t          mb;

  pdp8_sequencer pdp8_sequencer_i (
    .clock     (clock),
    .resetN    (resetN),
    .run       (run),
    .ir        (ir),
    .mb        (mb),
    .mem_ready (mem_ready),
    .ctrl      (ctrl),
    .mem_valid (mem_valid),
    .idle      (idle),
    .halted    (halted)
  );

  pdp8_accumulator pdp8_accumulator_i (
    .clock  (clock),
    .resetN (resetN),
    .ctrl   (ctrl),
    .ir     (ir),
    .mb     (mb),
    .ac     (ac),
    .link   (link)
  );

  pdp8_address_unit pdp8_address_unit_i (
    .clock     (clock),
    .resetN    (resetN),
    .ctrl      (ctrl),
    .start_pc  (start_pc),
    .ac        (ac),
    .mem_rdata (mem_rdata),
    .ir        (ir),
    .mb        (mb),
    .mem_req   (mem_req)
  );

endmodule

`default_nettype wire

//--- tb_pdp8_core.sv
// Testbench for the PDP-8 core with a stalling memory model and an instruction-level
// reference model that predicts every memory request and the final AC and link
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_config.svh"

module tb_pdp8_core;

  localparam int PROGRAMS = 24;
  localparam int TIMEOUT  = 4000;

  logic               clock = 1'b0;
  logic               resetN;
  logic               run;
  pdp8_pkg::word_t    start_pc;
  logic               mem_ready = 1'b0;
  pdp8_pkg::word_t    mem_rdata = '0;
  logic               mem_valid;
  pdp8_pkg::mem_req_t mem_req;
  pdp8_pkg::word_t    ac;
  logic               link;
  logic               idle;
  logic               halted;

  pdp8_pkg::word_t    mem [0:(1 << `PDP8_WORD_W)-1];
  pdp8_pkg::word_t    ref_mem [0:(1 << `PDP8_WORD_W)-1];
  pdp8_pkg::mem_req_t exp_q [$];
  pdp8_pkg::mem_req_t held_req;
  logic               stalled = 1'b0;
  integer             seed = 32'h57f8;
  int                 errors = 0;
  int                 timeouts = 0;
  int                 halt_count = 0;
  pdp8_pkg::word_t    model_ac = '0;
  logic               model_link = 1'b0;

  pdp8_core pdp8_core_i (
    .clock     (clock),
    .resetN    (resetN),
    .run       (run),
    .start_pc  (start_pc),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .ac        (ac),
    .link      (link),
    .idle      (idle),
    .halted    (halted)
  );

  always #10 clock = ~clock;

  task automatic check_req(input pdp8_pkg::mem_req_t got, input pdp8_pkg::mem_req_t exp,
                           input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s addr %o write %b data %o, expected addr %o write %b data %o",
               $time, what, got.addr, got.write, got.wdata, exp.addr, exp.write, exp.wdata);
    end
  endtask

  task automatic check_word(input pdp8_pkg::word_t got, input pdp8_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %o, expected %o", $time, what, got, exp);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  function automatic pdp8_pkg::mem_req_t make_req(input pdp8_pkg::word_t addr,
                                                  input logic write,
                                                  input pdp8_pkg::word_t data);
    pdp8_pkg::mem_req_t r;
    r.addr  = addr;
    r.write = write;
    r.wdata = data;
    return r;
  endfunction

  // Memory model drives random ready, read data and writes on the falling edge
  always @(negedge clock) begin : memory_side
    pdp8_pkg::mem_req_t seen;
    pdp8_pkg::mem_req_t expected;
    logic               ready;
    if (resetN) begin
      if (stalled) begin
        if (!mem_valid) begin
          errors++;
          $display("Request withdrawn at %0t before memory accepted it", $time);
        end
        check_req(mem_req, held_req, "stalled request changed");
      end
      if (halted) halt_count++;
      ready     = rand_below(3) != 0;                  // Low about a third of the time
      mem_ready = ready;
      mem_rdata = mem[mem_req.addr];
      stalled   = mem_valid && !ready;
      held_req  = mem_req;
      if (mem_valid && ready) begin
        seen = mem_req;
        if (!seen.write) seen.wdata = '0;              // Write data means nothing on a read
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected request at %0t to address %o", $time, seen.addr);
        end else begin
          expected = exp_q.pop_front();
          check_req(seen, expected, "memory request");
        end
        if (seen.write) mem[seen.addr] = seen.wdata;
      end
    end else begin
      mem_ready = 1'b0;
      stalled   = 1'b0;
    end
  end

  // Group 1 order is clears, complements, increment, then a single rotate through link
  task automatic apply_operate(input pdp8_pkg::word_t w);
    logic [12:0] sum;
    logic        old_link;
    if (w[7]) model_ac = '0;
    if (w[6]) model_link = 1'b0;
    if (w[5]) model_ac = ~model_ac;
    if (w[4]) model_link = ~model_link;
    if (w[0]) begin
      sum      = {1'b0, model_ac} + 13'd1;
      model_ac = sum[11:0];
      if (sum[12]) model_link = ~model_link;
    end
    old_link = model_link;
    if (w[3]) begin
      model_link = model_ac[0];
      model_ac   = {old_link, model_ac[11:1]};
    end else if (w[2]) begin
      model_link = model_ac[11];
      model_ac   = {model_ac[10:0], old_link};
    end
  endtask

  // Interprets the program in ref_mem and queues every request it should issue
  task automatic run_model(input pdp8_pkg::word_t start);
    pdp8_pkg::word_t pc;
    pdp8_pkg::word_t w;
    pdp8_pkg::word_t ea;
    pdp8_pkg::word_t val;
    logic [12:0]     sum;
    int              steps;
    pc    = start;
    steps = 0;
    while (steps < 500) begin
      steps++;
      w = ref_mem[pc];
      exp_q.push_back(make_req(pc, 1'b0, '0));
      if (w == `PDP8_HLT_WORD) break;
      if (w[11:10] == 2'b11) begin                     // IOT and operate
        if (w[9] && !w[8]) apply_operate(w);
        pc = pc + 12'd1;
      end else begin
        ea = w[7] ? {pc[11:7], w[6:0]} : {5'd0, w[6:0]};
        if (w[8]) begin
          exp_q.push_back(make_req(ea, 1'b0, '0));
          ea = ref_mem[ea];
        end
        case (w[11:9])
          3'o0, 3'o1: begin
            exp_q.push_back(make_req(ea, 1'b0, '0));
            if (w[9]) begin
              sum      = {1'b0, model_ac} + {1'b0, ref_mem[ea]};
              model_ac = sum[11:0];
              if (sum[12]) model_link = ~model_link;
            end else begin
              model_ac = model_ac & ref_mem[ea];
            end
            pc = pc + 12'd1;
          end
          3'o2: begin
            exp_q.push_back(make_req(ea, 1'b0, '0));
            val = ref_mem[ea] + 12'd1;
            exp_q.push_back(make_req(ea, 1'b1, val));
            ref_mem[ea] = val;
            pc = pc + ((val == '0) ? 12'd2 : 12'd1);
          end
          3'o3: begin
            exp_q.push_back(make_req(ea, 1'b1, model_ac));
            ref_mem[ea] = model_ac;
            model_ac    = '0;
            pc          = pc + 12'd1;
          end
          3'o4: begin
            exp_q.push_back(make_req(ea, 1'b1, pc + 12'd1));
            ref_mem[ea] = pc + 12'd1;
            pc          = ea + 12'd1;
          end
          default: pc = ea;
        endcase
      end
    end
  endtask

  function automatic pdp8_pkg::word_t data_value();
    return (rand_below(4) == 0) ? 12'o7777 : 12'($random(seed));   // 7777 makes ISZ skip
  endfunction

  // Direct operands sit at offsets 64..95 and pointer words at 96..127
  function automatic pdp8_pkg::word_t mem_ref_word(input logic [2:0] op);
    logic indirect;
    logic page;
    indirect = rand_below(3) == 0;
    page     = rand_below(2) == 0;
    return {op, indirect, page, indirect ? 7'(96 + rand_below(32)) : 7'(64 + rand_below(32))};
  endfunction

  function automatic pdp8_pkg::word_t operate_word();
    logic [1:0] rot;
    rot = 2'(rand_below(3));                           // None, RAL or RAR
    return {3'o7, 1'b0, 4'(rand_below(16)), rot, 2'(rand_below(4))};
  endfunction

  task automatic build_program(output pdp8_pkg::word_t base);
    logic [4:0] code_page;
    logic [4:0] far_page;
    logic [2:0] data_op;
    int         a;
    int         pos;
    int         k;
    code_page = 5'(1 + rand_below(15));
    far_page  = 5'(16 + rand_below(16));               // Indirect operands live here
    base      = {code_page, 7'd0};
    for (a = 0; a < (1 << `PDP8_WORD_W); a++) mem[a] = 12'(a) ^ 12'o5252;
    for (a = 0; a < 128; a++) mem[{far_page, 7'(a)}] = data_value();
    for (a = 64; a < 128; a++) begin
      mem[{5'd0, 7'(a)}] = (a < 96) ? data_value() : {far_page, 7'(rand_below(128))};
      mem[{code_page, 7'(a)}] = (a < 96) ? data_value() : {far_page, 7'(rand_below(128))};
    end
    pos = 0;
    while (pos < 56) begin
      k = 1 + rand_below(3);
      case (rand_below(10))
        0, 1, 2: begin
          mem[base + 12'(pos)] = operate_word();
          pos++;
        end
        3: begin
          mem[base + 12'(pos)]     = mem_ref_word(3'o2);
          mem[base + 12'(pos + 1)] = rand_below(2) != 0 ? operate_word() :
                                                          mem_ref_word(3'(rand_below(2)));
          pos += 2;
        end
        4: begin
          mem[base + 12'(pos)] = {3'o5, 2'b01, 7'(pos + k)};   // Forward JMP
          pos += k;
        end
        5: begin
          mem[base + 12'(pos)] = {3'o4, 2'b01, 7'(pos + k)};   // Forward JMS
          pos += k + 1;
        end
        default: begin
          data_op = 3'(rand_below(3));
          if (data_op == 3'o2) data_op = 3'o3;         // ISZ only in pairs with its skip target
          mem[base + 12'(pos)] = mem_ref_word(data_op);
          pos++;
        end
      endcase
    end
    mem[base + 12'(pos)] = `PDP8_HLT_WORD;
    for (a = 0; a < (1 << `PDP8_WORD_W); a++) ref_mem[a] = mem[a];
  endtask

  task automatic wait_for_status(input bit for_halt, output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < TIMEOUT && !ok; cycles++) begin
      @(negedge clock);
      ok = for_halt ? halted : idle;
    end
    if (!ok) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT,
               for_halt ? "halted" : "idle");
    end
  endtask

  initial begin : stimulus
    pdp8_pkg::word_t base;
    bit              ok;
    int              prog;
    resetN   = 1'b0;
    run      = 1'b0;
    start_pc = '0;
    repeat (3) @(negedge clock);
    resetN = 1'b1;
    if (mem_valid || halted) begin
      errors++;
      $display("FAIL %0t: mem_valid or halted high after reset", $time);
    end
    wait_for_status(1'b0, ok);
    if (ok) begin
      check_word(ac, '0, "ac after reset");
      check_word({11'd0, link}, '0, "link after reset");
    end
    for (prog = 0; prog < PROGRAMS && ok; prog++) begin
      build_program(base);
      run_model(base);
      halt_count = 0;
      run        = 1'b1;
      start_pc   = base;
      @(negedge clock);
      run = 1'b0;
      wait_for_status(1'b1, ok);
      if (ok) begin
        @(negedge clock);
        if (!idle || halted || halt_count != 1) begin
          errors++;
          $display("FAIL %0t: program %0d gave %0d halted pulses, idle %b after halt",
                   $time, prog, halt_count, idle);
        end
        if (exp_q.size() != 0) begin
          errors++;
          $display("Program %0d halted with %0d predicted requests never issued",
                   prog, exp_q.size());
          exp_q.delete();
        end
        check_word(ac, model_ac, "final ac");
        check_word({11'd0, link}, {11'd0, model_link}, "final link");
      end
    end
    $display("Failed checks: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
pdp8_pkg.sv
pdp8_sequencer.sv
pdp8_accumulator.sv
pdp8_address_unit.sv
pdp8_core.sv
tb_pdp8_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PDP-8 core testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_pdp8_core -o sim_pdp8
./obj_dir/sim_pdp8 | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished without errors"
